//--- logic/uart_config.svh
////////////////////
// Build-time settings for the UART string link
// Bit timing, stop bits, string size and the frame marker
////////////////////

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

////////////////////
// Serial line timing
////////////////////

// Clock cycles per serial bit, kept small so simulation runs short
`define CLKS_PER_BIT 8

`define STOP_BITS 1 // The receiver only checks the first one

////////////////////
// String framing
////////////////////

`define MAX_STR_LEN 16 // Content bytes per string
`define FRAME_MARK 8'h26 // ASCII '&'

`endif

//--- logic/uart_line_pkg.sv
////////////////////
// Serial line types
// Received byte with status, transmitter state encoding
////////////////////

package uart_line_pkg;

	////////////////////
	// Receiver output
	////////////////////

	// One received byte as handed from the receiver to the framer
	typedef struct packed {
		logic       framing_err; // Stop bit was sampled low
		logic [7:0] data;
	} rx_byte_t;

	////////////////////
	// Transmitter
	////////////////////

	typedef enum logic [1:0] {
		line_idle  = 2'd0, // Line high, ready for a byte
		line_start = 2'd1,
		line_data  = 2'd2, // Eight data bits, LSB first
		line_stop  = 2'd3
	} tx_line_state_e;

endpackage

//--- logic/string_frame_pkg.sv
////////////////////
// String frame types
// String buffer and the states of both framer machines
////////////////////

`include "uart_config.svh"

package string_frame_pkg;

	// Length is at least a byte wide, more if the buffer needs it
	localparam int LEN_W = ($clog2(`MAX_STR_LEN + 1) > 8) ? $clog2(`MAX_STR_LEN + 1) : 8;

	typedef logic [LEN_W-1:0] str_len_t;

	// Byte 0 goes out first and sits in the lowest bits
	typedef struct packed {
		str_len_t                        len;
		logic [`MAX_STR_LEN-1:0][7:0]    data;
	} string_buf_t;

	typedef enum logic [2:0] {
		ft_idle     = 3'd0,
		ft_mark1    = 3'd1,
		ft_mark2    = 3'd2,
		ft_content  = 3'd3,
		ft_mark3    = 3'd4,
		ft_mark4    = 3'd5,
		ft_wait_rel = 3'd6 // Ack is high, waiting for req to drop
	} frame_tx_state_e;

	typedef enum logic [2:0] {
		fr_hunt     = 3'd0, // Looking for the opening marker pair
		fr_mark_one = 3'd1,
		fr_content  = 3'd2,
		fr_mark_in  = 3'd3  // One marker seen inside the content
	} frame_rx_state_e;

endpackage

//--- logic/uart_tx_core.sv
////////////////////
// UART transmitter
// Sends one byte per start pulse, LSB first
////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_core import uart_line_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       tx_ready,
	output logic       uart_tx_port
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [2:0] STOP_END = 3'(`STOP_BITS - 1);

	tx_line_state_e   state;
	logic [CNT_W-1:0] clk_cnt; // Cycles spent in the current bit
	logic [2:0]       bit_idx; // Data bit, then reused for stop bits
	logic [7:0]       shift_q;
	logic             bit_end;

	assign bit_end  = (clk_cnt == BIT_END);
	assign tx_ready = (state == line_idle);

	// Byte is taken on start and shifted at the end of every data bit
	always_ff @(posedge sys_clk) begin
		if (state == line_idle && tx_start)
			shift_q <= tx_byte;
		else if (state == line_data && bit_end)
			shift_q <= {1'b0, shift_q[7:1]};
	end

	////////////////////
	// Bit sequencer
	////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= line_idle;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			uart_tx_port <= 1'b1;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				line_idle: begin
					clk_cnt <= '0;
					if (tx_start) begin
						state        <= line_start;
						uart_tx_port <= 1'b0; // Start bit on the next cycle
					end
				end
				line_start: if (bit_end) begin
					state        <= line_data;
					bit_idx      <= '0;
					uart_tx_port <= shift_q[0];
				end
				line_data: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state        <= line_stop;
						bit_idx      <= '0;
						uart_tx_port <= 1'b1;
					end else begin
						bit_idx      <= bit_idx + 1'b1;
						uart_tx_port <= shift_q[1]; // Shift happens on this same edge
					end
				end
				line_stop: if (bit_end) begin
					if (bit_idx == STOP_END)
						state <= line_idle;
					else
						bit_idx <= bit_idx + 1'b1;
				end
				default: state <= line_idle;
			endcase
		end
	end

endmodule

//--- logic/uart_rx_core.sv
////////////////////
// UART receiver
// Synchronizer, start bit check, mid-bit sampling, framing flag
////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx_core import uart_line_pkg::*; (
	input  logic     sys_clk,
	input  logic     sys_rst_n,
	input  logic     uart_rx_port,
	output rx_byte_t rx_data,
	output logic     rx_strobe
);

	localparam int CNT_W = $clog2(`CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(`CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		rx_idle,
		rx_start, // Waiting for the middle of the start bit
		rx_data_bits,
		rx_stop
	} rx_state_e;

	rx_state_e        state;
	logic [1:0]       sync_q; // Two flops against metastability
	logic             line_prev;
	logic             line_s;
	logic             line_fall;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_q;

	assign line_s    = sync_q[1];
	assign line_fall = line_prev && !line_s;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_q    <= 2'b11; // Idle line is high
			line_prev <= 1'b1;
		end else begin
			sync_q    <= {sync_q[0], uart_rx_port};
			line_prev <= line_s;
		end
	end

	// Data bits arrive LSB first so they enter from the top
	always_ff @(posedge sys_clk) begin
		if (state == rx_data_bits && clk_cnt == BIT_END)
			shift_q <= {line_s, shift_q[7:1]};
		if (state == rx_stop && clk_cnt == BIT_END) begin
			rx_data.data        <= shift_q;
			rx_data.framing_err <= !line_s;
		end
	end

	////////////////////
	// Receive sequencer
	////////////////////

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= rx_idle;
			clk_cnt   <= '0;
			bit_idx   <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rx_strobe <= 1'b0;
			clk_cnt   <= clk_cnt + 1'b1;
			case (state)
				rx_idle: begin
					clk_cnt <= '0;
					if (line_fall)
						state <= rx_start;
				end
				rx_start: if (clk_cnt == HALF_END) begin
					// A glitch is already back high at half a bit
					state   <= line_s ? rx_idle : rx_data_bits;
					clk_cnt <= '0;
					bit_idx <= '0;
				end
				rx_data_bits: if (clk_cnt == BIT_END) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= rx_stop;
				end
				rx_stop: if (clk_cnt == BIT_END) begin
					state     <= rx_idle; // Second half of the stop bit is idle time
					rx_strobe <= 1'b1;
				end
				default: state <= rx_idle;
			endcase
		end
	end

endmodule

//--- logic/uart_string_handle.sv
////////////////////
// String framer
// Wraps outgoing strings in marker pairs behind a req/ack handshake
// Rebuilds incoming strings from the received bytes
////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module uart_string_handle import uart_line_pkg::*, string_frame_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  string_buf_t tx_msg,
	input  logic        tx_req,
	output logic        tx_ack,
	output logic        tx_busy,
	output string_buf_t rx_msg,
	output logic        rx_valid,
	output logic [7:0]  tx_byte,
	output logic        tx_start,
	input  logic        tx_ready,
	input  rx_byte_t    rx_data,
	input  logic        rx_strobe
);

	localparam logic [7:0] MARK = `FRAME_MARK;

	frame_tx_state_e tx_state;
	frame_rx_state_e rx_state;
	string_buf_t     tx_buf; // Copy of the host string for the whole frame
	string_buf_t     cap_buf; // Frame under capture
	str_len_t        tx_idx; // Next content byte to queue
	logic            tx_pend; // tx_byte waits for the core
	logic            tx_ready_q;
	logic            tx_ready_rise;
	logic            rx_is_mark;

	// Appends one byte unless the buffer is already full
	function automatic string_buf_t put_byte(string_buf_t b, logic [7:0] d);
		if (b.len < `MAX_STR_LEN) begin
			b.data[b.len] = d;
			b.len         = b.len + 1'b1;
		end
		return b;
	endfunction

	////////////////////
	// Transmit side
	////////////////////

	// The next byte is queued while the current one is still on the line
	assign tx_start      = tx_pend && tx_ready;
	assign tx_ready_rise = tx_ready && !tx_ready_q; // Byte done

	always_ff @(posedge sys_clk) begin
		if (tx_state == ft_idle && tx_req && !tx_ack) begin
			tx_buf <= tx_msg;
			if (tx_msg.len > `MAX_STR_LEN)
				tx_buf.len <= str_len_t'(`MAX_STR_LEN);
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state   <= ft_idle;
			tx_byte    <= 8'h00;
			tx_idx     <= '0;
			tx_pend    <= 1'b0;
			tx_ack     <= 1'b0;
			tx_busy    <= 1'b0;
			tx_ready_q <= 1'b1;
		end else begin
			tx_ready_q <= tx_ready;
			case (tx_state)
				ft_idle: if (tx_req && !tx_ack) begin
					tx_state <= ft_mark1;
					tx_byte  <= MARK;
					tx_pend  <= 1'b1;
					tx_busy  <= 1'b1;
				end
				ft_mark1: if (tx_start) begin
					tx_state <= ft_mark2;
					tx_byte  <= MARK;
				end
				ft_mark2: if (tx_start) begin
					if (tx_buf.len == '0) begin // Empty string, straight to the closing pair
						tx_state <= ft_mark3;
						tx_byte  <= MARK;
					end else begin
						tx_state <= ft_content;
						tx_byte  <= tx_buf.data[0];
						tx_idx   <= str_len_t'(1);
					end
				end
				ft_content: if (tx_start) begin
					if (tx_idx == tx_buf.len) begin
						tx_state <= ft_mark3;
						tx_byte  <= MARK;
					end else begin
						tx_byte <= tx_buf.data[tx_idx];
						tx_idx  <= tx_idx + 1'b1;
					end
				end
				ft_mark3: if (tx_start) begin
					tx_state <= ft_mark4;
					tx_byte  <= MARK;
				end
				ft_mark4: begin
					if (tx_start)
						tx_pend <= 1'b0;
					else if (!tx_pend && tx_ready_rise) begin // Last stop bit has ended
						tx_state <= ft_wait_rel;
						tx_ack   <= 1'b1;
					end
				end
				ft_wait_rel: if (!tx_req) begin
					tx_state <= ft_idle;
					tx_ack   <= 1'b0;
					tx_busy  <= 1'b0;
				end
				default: tx_state <= ft_idle;
			endcase
		end
	end

	////////////////////
	// Receive side
	////////////////////

	assign rx_is_mark = (rx_data.data == MARK);

	always_ff @(posedge sys_clk) begin
		if (rx_strobe && !rx_data.framing_err) begin
			case (rx_state)
				fr_mark_one: if (rx_is_mark) cap_buf <= '0; // Frame opens
				fr_content: if (!rx_is_mark) cap_buf <= put_byte(cap_buf, rx_data.data);
				// A lone marker was content after all
				fr_mark_in: if (!rx_is_mark) cap_buf <= put_byte(put_byte(cap_buf, MARK), rx_data.data);
				default: ;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= fr_hunt;
			rx_msg   <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (rx_strobe) begin
				if (rx_data.framing_err)
					rx_state <= fr_hunt; // Broken byte drops the frame
				else begin
					case (rx_state)
						fr_hunt: if (rx_is_mark) rx_state <= fr_mark_one;
						fr_mark_one: rx_state <= rx_is_mark ? fr_content : fr_hunt;
						fr_content: if (rx_is_mark) rx_state <= fr_mark_in;
						fr_mark_in: begin
							if (rx_is_mark) begin
								rx_state <= fr_hunt;
								rx_msg   <= cap_buf;
								rx_valid <= 1'b1;
							end else
								rx_state <= fr_content;
						end
						default: rx_state <= fr_hunt;
					endcase
				end
			end
		end
	end

endmodule

//--- logic/uart_string_top.sv
////////////////////
// Top level of the UART string link
// Transmitter, receiver and string framer
////////////////////

`timescale 1ns/1ps

module uart_string_top import uart_line_pkg::*, string_frame_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst_n,
	input  string_buf_t tx_msg,
	input  logic        tx_req,
	output logic        tx_ack,
	output logic        tx_busy,
	output string_buf_t rx_msg,
	output logic        rx_valid,
	input  logic        uart_rx_port,
	output logic        uart_tx_port
);

	logic [7:0] tx_byte;
	logic       tx_start;
	logic       tx_ready;
	rx_byte_t   rx_data;
	logic       rx_strobe;

	uart_tx_core u_tx_core (
		.sys_clk, .sys_rst_n,
		.tx_byte, .tx_start, .tx_ready,
		.uart_tx_port
	);

	uart_rx_core u_rx_core (
		.sys_clk, .sys_rst_n,
		.uart_rx_port,
		.rx_data, .rx_strobe
	);

	// Framer sits between the host and both cores
	uart_string_handle u_string_handle (
		.sys_clk, .sys_rst_n,
		.tx_msg, .tx_req, .tx_ack, .tx_busy,
		.rx_msg, .rx_valid,
		.tx_byte, .tx_start, .tx_ready,
		.rx_data, .rx_strobe
	);

endmodule

//--- sim/tb_uart_string.sv
////////////////////
// Testbench for the UART string link
// Clock, reset, serial byte driver and monitor, loopback select
// Assertions for framing, handshake and receive rules, cycle timeout
////////////////////

`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_string import string_frame_pkg::*; ();

	localparam int CPB = `CLKS_PER_BIT;
	localparam logic [7:0] MARK = `FRAME_MARK;
	// Line bytes over all tests with the markers counted
	localparam int LINE_BYTES = 38 + 27 + 56;
	localparam int LIMIT_CYCLES = LINE_BYTES * 10 * CPB * 2 + 2000;

	typedef logic [7:0] byte_q_t[$];

	logic        sys_clk;
	logic        sys_rst_n;
	string_buf_t tx_msg;
	logic        tx_req;
	logic        tx_ack;
	logic        tx_busy;
	string_buf_t rx_msg;
	logic        rx_valid;
	logic        uart_rx_port;
	logic        uart_tx_port;
	logic        loop_en; // Receiver listens to the DUT's own transmitter
	logic        drv_line; // Output of the serial byte driver

	integer      seed;
	int          errors = 0;
	int          test_errs = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	int          rx_count = 0; // rx_valid pulses seen so far
	int          idle_run; // Cycles since uart_tx_port was last low
	int          cycles;
	string_buf_t rx_last;
	byte_q_t     mon_q; // Bytes decoded from uart_tx_port
	int          tx_lens[4] = '{0, 1, 5, `MAX_STR_LEN};
	int          loop_lens[2] = '{3, `MAX_STR_LEN};

	assign uart_rx_port = loop_en ? uart_tx_port : drv_line;

	uart_string_top UUT (.*);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic log_error(input string what);
		errors++;
		$display("ERROR %s at %0t ns", what, $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s expected %h got %h", name, exp, got);
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_errs) begin
			n_pass++;
			$display("test %s passed", name);
		end else begin
			n_fail++;
			$display("test %s failed with %0d errors", name, errors - test_errs);
		end
		test_errs = errors;
	endtask

	// Handshake rules on the host side
	ack_needs_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_ack) |-> tx_req) else log_error("tx_ack rose while tx_req was low");
	ack_after_stop: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$rose(tx_ack) |-> idle_run >= CPB) else log_error("tx_ack rose before the stop bit ended");
	ack_drops: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(tx_req) |=> !tx_ack) else log_error("tx_ack stayed high after tx_req fell");
	busy_in_frame: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!uart_tx_port |-> tx_busy) else log_error("tx_busy was low with a bit on the line");

	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			idle_run <= 0;
		else
			idle_run <= uart_tx_port ? idle_run + 1 : 0;
	end

	always @(negedge sys_clk) begin
		if (rx_valid) begin
			rx_count++;
			rx_last = rx_msg; // Captured while the pulse is stable
		end
	end

	// Samples each bit of uart_tx_port near its middle
	always begin : line_monitor
		logic [7:0] b;
		@(negedge sys_clk);
		if (sys_rst_n && !uart_tx_port) begin
			repeat (CPB / 2) @(negedge sys_clk);
			for (int i = 0; i < 8; i++) begin
				repeat (CPB) @(negedge sys_clk);
				b[i] = uart_tx_port;
			end
			repeat (CPB) @(negedge sys_clk);
			check_value("uart_tx_port stop bit", 1, uart_tx_port);
			mon_q.push_back(b);
		end
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	// Start bit, data LSB first, stop bit, one idle bit
	task automatic send_byte(input logic [7:0] data, input logic stop_ok);
		logic [10:0] bits;
		bits = {1'b1, stop_ok, data, 1'b0};
		@(posedge sys_clk);
		for (int i = 0; i < 11; i++) begin
			drv_line <= bits[i];
			repeat (CPB) @(posedge sys_clk);
		end
	endtask

	task automatic drive_seq(input byte_q_t q);
		foreach (q[i])
			send_byte(q[i], 1'b1);
	endtask

	function automatic string_buf_t random_string(input int len);
		string_buf_t b;
		logic [7:0]  c;
		b = '0;
		b.len = str_len_t'(len);
		for (int i = 0; i < len; i++) begin
			c = 8'($random(seed));
			b.data[i] = (c == MARK) ? 8'h2a : c; // Random content holds no markers
		end
		return b;
	endfunction

	function automatic string_buf_t to_buf(input byte_q_t q);
		string_buf_t b;
		b = '0;
		foreach (q[i])
			if (i < `MAX_STR_LEN) begin
				b.data[i] = q[i];
				b.len = str_len_t'(i + 1);
			end
		return b;
	endfunction

	task automatic check_msg(input string_buf_t exp, input string_buf_t got);
		check_value("rx_msg.len", 32'(exp.len), 32'(got.len));
		for (int i = 0; i < exp.len; i++)
			check_value($sformatf("rx_msg.data[%0d]", i), 32'(exp.data[i]), 32'(got.data[i]));
	endtask

	// Full four-phase transfer, then compares the monitored frame
	task automatic host_send(input string_buf_t msg);
		byte_q_t exp;
		exp = {MARK, MARK};
		for (int i = 0; i < msg.len; i++)
			exp.push_back(msg.data[i]);
		exp.push_back(MARK);
		exp.push_back(MARK);
		mon_q.delete();
		@(posedge sys_clk);
		tx_msg <= msg;
		tx_req <= 1'b1;
		repeat (2) @(negedge sys_clk);
		check_value("tx_busy", 1, tx_busy);
		while (!tx_ack)
			@(negedge sys_clk);
		check_value("monitored byte count", exp.size(), mon_q.size());
		foreach (exp[i])
			if (i < mon_q.size())
				check_value($sformatf("uart_tx_port byte %0d", i), exp[i], mon_q[i]);
		@(posedge sys_clk);
		tx_req <= 1'b0;
		while (tx_ack)
			@(negedge sys_clk);
		check_value("tx_busy", 0, tx_busy);
	endtask

	// Waits for the pulse count to reach target, then checks no extra pulse follows
	task automatic wait_frames(input int target);
		while (rx_count < target)
			@(negedge sys_clk);
		repeat (2 * CPB) @(negedge sys_clk);
		check_value("rx_valid pulse count", target, rx_count);
	endtask

	task automatic rx_case(input string name, input byte_q_t sent, input byte_q_t kept);
		int base;
		base = rx_count;
		drive_seq(sent);
		wait_frames(base + 1);
		check_msg(to_buf(kept), rx_last);
		end_test(name);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		byte_q_t     sent;
		byte_q_t     kept;
		string_buf_t msg;
		int          base;
		seed      = 32'h3ed9_f65d;
		sys_rst_n = 1'b0;
		tx_msg    = '0;
		tx_req    = 1'b0;
		loop_en   = 1'b0;
		drv_line  = 1'b1;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(negedge sys_clk);
		check_value("uart_tx_port", 1, uart_tx_port);
		check_value("tx_ack", 0, tx_ack);
		check_value("tx_busy", 0, tx_busy);
		check_value("rx_valid", 0, rx_valid);
		check_value("rx_msg.len", 0, 32'(rx_msg.len));
		end_test("reset state");

		foreach (tx_lens[i]) begin
			host_send(random_string(tx_lens[i]));
			end_test($sformatf("transmit length %0d", tx_lens[i]));
		end

		@(posedge sys_clk);
		loop_en <= 1'b1;
		foreach (loop_lens[i]) begin
			msg  = random_string(loop_lens[i]);
			base = rx_count;
			host_send(msg);
			wait_frames(base + 1);
			check_msg(msg, rx_last);
			end_test($sformatf("loopback length %0d", loop_lens[i]));
		end

		@(posedge sys_clk);
		loop_en <= 1'b0;
		sent = {8'h78, 8'h79, 8'h7a, MARK, MARK, 8'h61, 8'h62, MARK, MARK}; // xyz&&ab&&
		kept = {8'h61, 8'h62};
		rx_case("noise before frame", sent, kept);
		sent = {MARK, 8'h51, MARK, MARK, 8'h63, 8'h64, MARK, MARK}; // &Q&&cd&&
		kept = {8'h63, 8'h64};
		rx_case("single marker then letter", sent, kept);
		sent = {MARK, MARK, 8'h61, MARK, 8'h62, MARK, MARK};
		kept = {8'h61, MARK, 8'h62}; // Lone marker stays in the string
		rx_case("lone marker in content", sent, kept);
		sent = {MARK, MARK};
		kept.delete();
		for (int i = 0; i < `MAX_STR_LEN + 4; i++) begin
			sent.push_back(8'(8'h41 + i));
			if (i < `MAX_STR_LEN)
				kept.push_back(8'(8'h41 + i));
		end
		sent.push_back(MARK);
		sent.push_back(MARK);
		rx_case("overlong frame", sent, kept);

		// A low stop bit in the middle abandons the frame
		base = rx_count;
		sent = {MARK, MARK, 8'h61, 8'h62};
		drive_seq(sent);
		send_byte(8'h63, 1'b0);
		sent = {8'h64, MARK, MARK};
		drive_seq(sent);
		wait_frames(base);
		end_test("framing error");

		$display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < LIMIT_CYCLES) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

//--- flist.f
+incdir+logic
logic/uart_line_pkg.sv
logic/string_frame_pkg.sv
logic/uart_tx_core.sv
logic/uart_rx_core.sv
logic/uart_string_handle.sv
logic/uart_string_top.sv
sim/tb_uart_string.sv

//--- Makefile
# Verilator build for the UART string link testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_uart_string
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass message appears on a line of its own
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
